// ==== logic/reconPkg.sv ====
package reconPkg;

    // Reciprocal multiply shift of the quantizer
    localparam int QUANT_SHIFT = 17;

    // Final step of one block
    localparam int LAST_STEP = 5;

    typedef logic signed [15:0] coeff_t;

    // Raster order, index 0 at top left
    typedef logic [15:0][7:0] pixelBlock_t;

    // Raster order, index 0 is DC
    typedef coeff_t [15:0] coeffBlock_t;

    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
    } quantSet_t;

    typedef struct packed {
        logic fwdRow;
        logic fwdCol;
        logic quant;
        logic invRow;
        logic invCol;
    } stageEn_t;

endpackage

// ==== logic/stepCounter.sv ====
`timescale 1ns/1ps

module stepCounter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear_i,
    input  logic       run_i,
    output logic [2:0] step_o
);

    logic atLast;

    assign atLast = (step_o == 3'(reconPkg::LAST_STEP));

    // Holds at the final step until cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_o <= '0;
        end else if (clear_i) begin
            step_o <= '0;
        end else if (run_i && !atLast) begin
            step_o <= step_o + 3'd1;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (!rst_n)
        step_o <= 3'(reconPkg::LAST_STEP));

endmodule

// ==== logic/reconCtrl.sv ====
`timescale 1ns/1ps

module reconCtrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic [2:0]         step_i,
    output logic               stepClear_o,
    output logic               stepRun_o,
    output reconPkg::stageEn_t stageEn_o,
    output logic               done_o
);

    localparam logic IDLE = 1'b0;
    localparam logic RUN  = 1'b1;

    logic state;
    logic lastStep;
    logic accept;

    assign lastStep = (step_i == 3'(reconPkg::LAST_STEP));

    // Last step hands over to a waiting start, so a new block may begin at edge 6
    assign accept = start_i && ((state == IDLE) || lastStep);

    assign stepClear_o = accept;
    assign stepRun_o   = (state == RUN);
    assign done_o      = (state == RUN) && lastStep;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (accept) begin
            state <= RUN;
        end else if (done_o) begin
            state <= IDLE;
        end
    end

    // One stage per step
    always_comb begin
        stageEn_o = '0;
        if (state == RUN) begin
            case (step_i)
                3'd0: stageEn_o.fwdRow = 1'b1;
                3'd1: stageEn_o.fwdCol = 1'b1;
                3'd2: stageEn_o.quant  = 1'b1;
                3'd3: stageEn_o.invRow = 1'b1;
                3'd4: stageEn_o.invCol = 1'b1;
                default: ;
            endcase
        end
    end

    stageOneHot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(stageEn_o));

    donePulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o);

endmodule

// ==== logic/fwdTransform.sv ====
`timescale 1ns/1ps

module fwdTransform (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rowEn_i,
    input  logic                  colEn_i,
    input  reconPkg::pixelBlock_t src_i,
    input  reconPkg::pixelBlock_t pred_i,
    output reconPkg::coeffBlock_t coeff_o
);

    reconPkg::coeffBlock_t rowQ;
    reconPkg::coeffBlock_t rowNext;
    reconPkg::coeffBlock_t colNext;

    // ----------------------------------------------------------------------
    // Horizontal pass on src minus pred
    // ----------------------------------------------------------------------
    always_comb begin
        logic signed [31:0] d0, d1, d2, d3;
        logic signed [31:0] a0, a1, a2, a3;
        for (int r = 0; r < 4; r++) begin
            d0 = 32'(src_i[4*r])     - 32'(pred_i[4*r]);
            d1 = 32'(src_i[4*r + 1]) - 32'(pred_i[4*r + 1]);
            d2 = 32'(src_i[4*r + 2]) - 32'(pred_i[4*r + 2]);
            d3 = 32'(src_i[4*r + 3]) - 32'(pred_i[4*r + 3]);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            rowNext[4*r]     = 16'((a0 + a1) * 8);
            rowNext[4*r + 1] = 16'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
            rowNext[4*r + 2] = 16'((a0 - a1) * 8);
            rowNext[4*r + 3] = 16'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
        end
    end

    // ----------------------------------------------------------------------
    // Vertical pass with final rounding
    // ----------------------------------------------------------------------
    always_comb begin
        logic signed [31:0] a0, a1, a2, a3;
        logic signed [31:0] odd;
        for (int c = 0; c < 4; c++) begin
            a0 = rowQ[c] + rowQ[12 + c];
            a1 = rowQ[4 + c] + rowQ[8 + c];
            a2 = rowQ[4 + c] - rowQ[8 + c];
            a3 = rowQ[c] - rowQ[12 + c];
            odd = (a2 * 2217 + a3 * 5352 + 12000) >>> 16;
            colNext[c]      = 16'((a0 + a1 + 7) >>> 4);
            // Nonzero a3 bumps the first odd coefficient
            colNext[4 + c]  = 16'(odd + ((a3 != 0) ? 32'sd1 : 32'sd0));
            colNext[8 + c]  = 16'((a0 - a1 + 7) >>> 4);
            colNext[12 + c] = 16'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowQ    <= '0;
            coeff_o <= '0;
        end else begin
            if (rowEn_i) begin
                rowQ <= rowNext;
            end
            if (colEn_i) begin
                coeff_o <= colNext;
            end
        end
    end

endmodule

// ==== logic/quantizer.sv ====
`timescale 1ns/1ps

module quantizer #(
    parameter int LEVEL_MAX = 2047
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en_i,
    input  reconPkg::coeffBlock_t coeff_i,
    input  reconPkg::quantSet_t   dcQuant_i,
    input  reconPkg::quantSet_t   acQuant_i,
    output reconPkg::coeffBlock_t levels_o,
    output reconPkg::coeffBlock_t dequant_o,
    output logic                  nonzero_o
);

    reconPkg::coeffBlock_t levelNext;
    reconPkg::coeffBlock_t dequantNext;
    logic                  nonzeroNext;

    always_comb begin
        reconPkg::quantSet_t quantSet;
        logic [15:0] mag;
        logic [33:0] scaled;
        nonzeroNext = 1'b0;
        for (int i = 0; i < 16; i++) begin
            // DC set for index 0 only
            quantSet = (i == 0) ? dcQuant_i : acQuant_i;
            mag = coeff_i[i][15] ? 16'(-coeff_i[i]) : 16'(coeff_i[i]);
            scaled = (34'(mag) * 34'(quantSet.iq) + 34'(quantSet.bias))
                     >> reconPkg::QUANT_SHIFT;
            if (scaled > 34'(LEVEL_MAX)) begin
                scaled = 34'(LEVEL_MAX);
            end
            levelNext[i]   = coeff_i[i][15] ? -16'(scaled) : 16'(scaled);
            dequantNext[i] = 16'(levelNext[i] * $signed(quantSet.q));
            if (scaled != '0) begin
                nonzeroNext = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levels_o  <= '0;
            dequant_o <= '0;
            nonzero_o <= 1'b0;
        end else if (en_i) begin
            levels_o  <= levelNext;
            dequant_o <= dequantNext;
            nonzero_o <= nonzeroNext;
        end
    end

endmodule

// ==== logic/invTransform.sv ====
`timescale 1ns/1ps

module invTransform (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rowEn_i,
    input  logic                  colEn_i,
    input  reconPkg::coeffBlock_t coeff_i,
    input  reconPkg::pixelBlock_t pred_i,
    output reconPkg::pixelBlock_t recon_o
);

    logic signed [19:0]    vertQ    [16];
    logic signed [19:0]    vertNext [16];
    reconPkg::pixelBlock_t reconNext;

    // sqrt(2)*cos(pi/8) scaling
    function automatic logic signed [39:0] mul1(input logic signed [39:0] a);
        return ((a * 40'sd20091) >>> 16) + a;
    endfunction

    // sqrt(2)*sin(pi/8) scaling
    function automatic logic signed [39:0] mul2(input logic signed [39:0] a);
        return (a * 40'sd35468) >>> 16;
    endfunction

    function automatic logic [7:0] clip8(input logic signed [39:0] v);
        if (v < 0) begin
            return 8'd0;
        end else if (v > 255) begin
            return 8'd255;
        end
        return v[7:0];
    endfunction

    // ----------------------------------------------------------------------
    // Vertical pass first, as in the VP8 decoder
    // ----------------------------------------------------------------------
    always_comb begin
        logic signed [39:0] a, b, c, d;
        for (int col = 0; col < 4; col++) begin
            a = coeff_i[col] + coeff_i[8 + col];
            b = coeff_i[col] - coeff_i[8 + col];
            c = mul2(coeff_i[4 + col]) - mul1(coeff_i[12 + col]);
            d = mul1(coeff_i[4 + col]) + mul2(coeff_i[12 + col]);
            vertNext[col]      = 20'(a + d);
            vertNext[4 + col]  = 20'(b + c);
            vertNext[8 + col]  = 20'(b - c);
            vertNext[12 + col] = 20'(a - d);
        end
    end

    // ----------------------------------------------------------------------
    // Horizontal pass, round, add prediction, clip
    // ----------------------------------------------------------------------
    always_comb begin
        logic signed [39:0] dc, a, b, c, d;
        logic signed [39:0] sum [4];
        logic signed [39:0] pixel;
        for (int row = 0; row < 4; row++) begin
            dc = vertQ[4*row] + 40'sd4;
            a  = dc + vertQ[4*row + 2];
            b  = dc - vertQ[4*row + 2];
            c  = mul2(vertQ[4*row + 1]) - mul1(vertQ[4*row + 3]);
            d  = mul1(vertQ[4*row + 1]) + mul2(vertQ[4*row + 3]);
            sum[0] = a + d;
            sum[1] = b + c;
            sum[2] = b - c;
            sum[3] = a - d;
            for (int col = 0; col < 4; col++) begin
                pixel = (sum[col] >>> 3) + $signed({32'd0, pred_i[4*row + col]});
                reconNext[4*row + col] = clip8(pixel);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vertQ   <= '{default: '0};
            recon_o <= '0;
        end else begin
            if (rowEn_i) begin
                vertQ <= vertNext;
            end
            if (colEn_i) begin
                recon_o <= reconNext;
            end
        end
    end

endmodule

// ==== logic/chromaRecon.sv ====
`timescale 1ns/1ps

module chromaRecon #(
    parameter int LEVEL_MAX = 2047
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  reconPkg::pixelBlock_t src_i,
    input  reconPkg::pixelBlock_t pred_i,
    input  reconPkg::quantSet_t   dcQuant_i,
    input  reconPkg::quantSet_t   acQuant_i,
    output reconPkg::coeffBlock_t levels_o,
    output reconPkg::pixelBlock_t recon_o,
    output logic                  nonzero_o,
    output logic                  done_o
);

    logic                  stepClear;
    logic                  stepRun;
    logic [2:0]            step;
    reconPkg::stageEn_t    stageEn;
    reconPkg::coeffBlock_t fwdCoeff;
    reconPkg::coeffBlock_t dequant;

    // ----------------------------------------------------------------------
    // Sequencing
    // ----------------------------------------------------------------------
    stepCounter u_stepCounter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (stepClear),
        .run_i   (stepRun),
        .step_o  (step)
    );

    reconCtrl u_reconCtrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .step_i      (step),
        .stepClear_o (stepClear),
        .stepRun_o   (stepRun),
        .stageEn_o   (stageEn),
        .done_o      (done_o)
    );

    // ----------------------------------------------------------------------
    // Data path
    // ----------------------------------------------------------------------
    fwdTransform u_fwdTransform (
        .clk     (clk),
        .rst_n   (rst_n),
        .rowEn_i (stageEn.fwdRow),
        .colEn_i (stageEn.fwdCol),
        .src_i   (src_i),
        .pred_i  (pred_i),
        .coeff_o (fwdCoeff)
    );

    quantizer #(
        .LEVEL_MAX (LEVEL_MAX)
    ) u_quantizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_i      (stageEn.quant),
        .coeff_i   (fwdCoeff),
        .dcQuant_i (dcQuant_i),
        .acQuant_i (acQuant_i),
        .levels_o  (levels_o),
        .dequant_o (dequant),
        .nonzero_o (nonzero_o)
    );

    invTransform u_invTransform (
        .clk     (clk),
        .rst_n   (rst_n),
        .rowEn_i (stageEn.invRow),
        .colEn_i (stageEn.invCol),
        .coeff_i (dequant),
        .pred_i  (pred_i),
        .recon_o (recon_o)
    );

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

// ==== dv/chromaReconTb.sv ====
`timescale 1ns/1ps

module chromaReconTb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_VECTORS  = 6;
    localparam int FIELDS       = 7;
    localparam int LATENCY      = 5;
    localparam int RESTART_VEC  = 2;
    localparam int CLAMP_FIRST  = 4;
    localparam int LEVEL_MAX    = 2047;
    localparam int TIMEOUT_NS   = NUM_VECTORS * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    reconPkg::pixelBlock_t src;
    reconPkg::pixelBlock_t pred;
    reconPkg::quantSet_t   dcQuant;
    reconPkg::quantSet_t   acQuant;
    reconPkg::coeffBlock_t levels;
    reconPkg::pixelBlock_t recon;
    logic                  nonzero;
    logic                  done;

    // Fields per block are src pred dcQuant acQuant levels recon nonzero
    logic [255:0] vectorMem [NUM_VECTORS * FIELDS];

    int errorCount;
    int checkCount;

    clockGen #(
        .PERIOD_NS (CLK_PERIOD)
    ) u_clockGen (
        .clk_o (clk)
    );

    chromaRecon #(
        .LEVEL_MAX (LEVEL_MAX)
    ) u_chromaRecon (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start),
        .src_i     (src),
        .pred_i    (pred),
        .dcQuant_i (dcQuant),
        .acQuant_i (acQuant),
        .levels_o  (levels),
        .recon_o   (recon),
        .nonzero_o (nonzero),
        .done_o    (done)
    );

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic checkValue(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic checkCondition(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            errorCount++;
            $display("Error: %s", what);
        end
    endtask

    // ----------------------------------------------------------------------
    // One block from start to done
    // ----------------------------------------------------------------------
    task automatic runBlock(input int idx);
        logic [255:0] expLevels;
        logic [255:0] expRecon;
        logic         expNonzero;
        int           cycles;
        int           levelMag;
        string        name;
        expLevels  = vectorMem[idx * FIELDS + 4];
        expRecon   = vectorMem[idx * FIELDS + 5];
        expNonzero = vectorMem[idx * FIELDS + 6][0];
        name       = $sformatf("vector %0d", idx);
        @(negedge clk);
        src     = vectorMem[idx * FIELDS][127:0];
        pred    = vectorMem[idx * FIELDS + 1][127:0];
        dcQuant = vectorMem[idx * FIELDS + 2][63:0];
        acQuant = vectorMem[idx * FIELDS + 3][63:0];
        start   = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        // Extra start two cycles in must be dropped
        while (!done && cycles < 4 * LATENCY) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            start = (idx == RESTART_VEC) && (cycles == 2);
        end
        start = 1'b0;
        checkCondition(done, $sformatf("%s never raised done_o", name));
        checkValue({name, " latency"}, 256'(LATENCY), 256'(cycles));
        checkValue({name, " levels"}, expLevels, levels);
        checkValue({name, " recon"}, expRecon, 256'(recon));
        checkValue({name, " nonzero"}, 256'(expNonzero), 256'(nonzero));
        if (src == pred) begin
            checkValue({name, " zero residual levels"}, '0, levels);
            checkValue({name, " zero residual recon"}, 256'(pred), 256'(recon));
            checkValue({name, " zero residual nonzero"}, '0, 256'(nonzero));
        end
        if (idx >= CLAMP_FIRST) begin
            levelMag = (levels[0] < 0) ? -int'(levels[0]) : int'(levels[0]);
            checkValue({name, " clamped DC magnitude"}, 256'(LEVEL_MAX), 256'(levelMag));
        end
        @(negedge clk);
        checkCondition(!done, $sformatf("%s held done_o longer than one cycle", name));
        if (idx == RESTART_VEC) begin
            // Long enough for a queued block to reach its done
            repeat (LATENCY + 2) begin
                @(negedge clk);
                checkCondition(!done, "done_o pulsed again after a start given while busy");
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        logic anyNonzero;
        errorCount = 0;
        checkCount = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        src        = '0;
        pred       = '0;
        dcQuant    = '0;
        acQuant    = '0;
        $readmemh("dv/recon_vectors.txt", vectorMem);
        anyNonzero = 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            anyNonzero = anyNonzero | vectorMem[i * FIELDS + 6][0];
        end
        checkCondition(anyNonzero, "vector file holds no nonzero block, it was probably not read");

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        checkCondition(!done, "done_o is high after reset");
        checkValue("reset levels", '0, levels);
        checkValue("reset recon", '0, 256'(recon));
        checkValue("reset nonzero", '0, 256'(nonzero));

        for (int i = 0; i < NUM_VECTORS; i++) begin
            runBlock(i);
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== dv/recon_vectors.txt ====
// Columns in hex: src pred dcQuant acQuant levels recon nonzero, one block per line
// Quantizer sets are q iq bias, pixels and levels have index 0 rightmost
00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 001020000000c000 000840000000c000 0000000000000000000000000000000000000000000000000000000000000000 00112233445566778899aabbccddeeff 0
595857565554535251504f4e4d4c4b4a 4f4e4d4c4b4a49484746454443424140 001020000000c000 000840000000c000 0000000000000000000000000000000000000000000000000000000000000005 595857565554535251504f4e4d4c4b4a 1
a8a4a09c9894908c8884807c7874706c bcb8b4b0aca8a4a09c9894908c888480 001020000000c000 000840000000c000 000000000000000000000000000000000000000000000000000000000000fff6 a8a4a09c9894908c8884807c7874706c 1
70709090707090907070909070709090 80808080808080808080808080808080 001020000000c000 000840000000c000 000000000000000000000000000000000000000000000000fffa0000000f0000 70709090707090907070909070709090 1
4b4a494847464544434241403f3e3d3c afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0001ffff10000000 000840000000c000 000000000000000000000000000000000000000000000000000000000000f801 00000000000000000000000000000000 1
939291908f8e8d8c8b8a898887868584 2f2e2d2c2b2a29282726252423222120 0001ffff10000000 000840000000c000 00000000000000000000000000000000000000000000000000000000000007ff ffffffffffffffffffffffffffffffff 1

// ==== chromaRecon.f ====
logic/reconPkg.sv
logic/stepCounter.sv
logic/reconCtrl.sv
logic/fwdTransform.sv
logic/quantizer.sv
logic/invTransform.sv
logic/chromaRecon.sv
dv/clockGen.sv
dv/chromaReconTb.sv

// ==== Makefile ====
TOP := chromaReconTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f chromaRecon.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f chromaRecon.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
